//--- Makefile
TOP = forwardTb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f forwardTop.f --top-module forwardTop

sim:
	verilator --binary --timing --assert -f forwardTop.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/forwardTb.sv
`timescale 1ns/1ns

module forwardTb import fwdPkg::*; ();

  localparam int dataWidth   = 65;
  localparam int flagWidth   = 6;
  localparam int resetCycles = 8;
  localparam int idleCycles  = 4;
  localparam int sweepCycles = 32;  // two sweeps over all 16 codes.
  localparam int fixedCycles = 16;
  localparam int randCycles  = 200;
  localparam int testCycles  = idleCycles + 2 * sweepCycles + 2 * fixedCycles + randCycles;

  logic                 clk;
  logic                 rst;
  logic                 stall;
  fwdSrcT               fuFwd;
  fwdSrcT               fuuFwd;
  logic                 auxEn;
  logic [dataWidth-1:0] regData;
  logic [flagWidth-1:0] regFlags;
  logic [dataWidth-1:0] auxData;
  logic [flagWidth-1:0] auxFlags;
  logic [dataWidth-1:0] fuData  [fuCount];
  logic [flagWidth-1:0] fuFlags [fuCount];
  logic [dataWidth-1:0] opData;
  logic [flagWidth-1:0] opFlags;

  // reference model state.
  logic [dataWidth-1:0] prevData  [fuCount];
  logic [flagWidth-1:0] prevFlags [fuCount];
  logic [dataWidth-1:0] expData;
  logic [flagWidth-1:0] expFlags;

  integer seed      = 32'hbfe;
  int     errors    = 0;
  int     checks    = 0;
  int     stallLeft = 0;

  forwardTop #(
    .dataWidth (dataWidth),
    .flagWidth (flagWidth)
  ) u_forwardTop (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .fuFwd    (fuFwd),
    .fuuFwd   (fuuFwd),
    .auxEn    (auxEn),
    .regData  (regData),
    .regFlags (regFlags),
    .auxData  (auxData),
    .auxFlags (auxFlags),
    .fuData   (fuData),
    .fuFlags  (fuFlags),
    .opData   (opData),
    .opFlags  (opFlags)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #((resetCycles + testCycles + 100) * 20);
    $display("watchdog expired at %0t, the test did not finish", $time);
    $display("TEST FAIL");
    $finish;
  end

  function automatic int randRange(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic logic [dataWidth-1:0] randData();
    logic [95:0] raw;
    raw = {$random(seed), $random(seed), $random(seed)};
    return raw[dataWidth-1:0];
  endfunction

  function automatic logic [flagWidth-1:0] randFlags();
    logic [31:0] raw;
    raw = $random(seed);
    return raw[flagWidth-1:0];
  endfunction

  // codes 9..14 share the last unit.
  function automatic int modelUnit(input fwdSrcT code);
    if (code >= 4'd9) begin
      return 9;
    end
    return int'(code);
  endfunction

  // stall comes in bursts of 1 to 4 cycles.
  function automatic logic nextStall();
    if (stallLeft == 0 && randRange(5) == 0) begin
      stallLeft = 1 + randRange(4);
    end
    if (stallLeft > 0) begin
      stallLeft--;
      return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic compareData(input logic [dataWidth-1:0] actual,
                             input logic [dataWidth-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL opData actual %h expected %h at %0t", actual, expected, $time);
    end
  endtask

  task automatic compareFlags(input logic [flagWidth-1:0] actual,
                              input logic [flagWidth-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL opFlags actual %h expected %h at %0t", actual, expected, $time);
    end
  endtask

  task automatic driveInputs(input fwdSrcT fu, input fwdSrcT fuu, input logic aux,
                             input logic stl);
    fuFwd    = fu;
    fuuFwd   = fuu;
    auxEn    = aux;
    stall    = stl;
    regData  = randData();
    regFlags = randFlags();
    auxData  = randData();
    auxFlags = randFlags();
    for (int i = 0; i < fuCount; i++) begin
      fuData[i]  = randData();
      fuFlags[i] = randFlags();
    end
  endtask

  // what the slot captures on the coming edge.
  task automatic updateModel();
    logic [dataWidth-1:0] nextData;
    logic [flagWidth-1:0] nextFlags;
    if (fuFwd != srcNone) begin
      nextData  = fuData[modelUnit(fuFwd)];
      nextFlags = fuFlags[modelUnit(fuFwd)];
    end else if (auxEn) begin
      nextData  = auxData;
      nextFlags = auxFlags;
    end else if (fuuFwd != srcNone) begin
      nextData  = prevData[modelUnit(fuuFwd)];
      nextFlags = prevFlags[modelUnit(fuuFwd)];
    end else begin
      nextData  = regData;
      nextFlags = regFlags;
    end
    if (!stall) begin
      expData  = nextData;
      expFlags = nextFlags;
    end
    for (int i = 0; i < fuCount; i++) begin
      prevData[i]  = fuData[i];  // history ignores stall.
      prevFlags[i] = fuFlags[i];
    end
  endtask

  // check just before the edge, then move to the next drive point.
  task automatic finishCycle();
    #16;
    compareData(opData, expData);
    compareFlags(opFlags, expFlags);
    updateModel();
    @(posedge clk);
    #2;
  endtask

  initial begin
    fwdSrcT code;
    int     mode;
    logic   aux;
    logic   stl;
    rst      = 1'b1;
    stall    = 1'b0;
    fuFwd    = srcNone;
    fuuFwd   = srcNone;
    auxEn    = 1'b0;
    regData  = '0;
    regFlags = '0;
    auxData  = '0;
    auxFlags = '0;
    expData  = '0;
    expFlags = '0;
    for (int i = 0; i < fuCount; i++) begin
      fuData[i]    = '0;
      fuFlags[i]   = '0;
      prevData[i]  = '0;
      prevFlags[i] = '0;
    end
    repeat (resetCycles) @(posedge clk);
    #2;
    rst = 1'b0;
    compareData(opData, '0);
    compareFlags(opFlags, '0);

    // idle after reset, register file reads zero.
    for (int n = 0; n < idleCycles; n++) begin
      driveInputs(srcNone, srcNone, 1'b0, 1'b0);
      regData  = '0;
      regFlags = '0;
      finishCycle();
    end
    for (int n = 0; n < sweepCycles; n++) begin
      driveInputs(fwdSrcT'(n % 16), srcNone, 1'b0, 1'b0);
      finishCycle();
    end
    for (int n = 0; n < sweepCycles; n++) begin
      driveInputs(srcNone, fwdSrcT'(n % 16), 1'b0, 1'b0);
      finishCycle();
    end
    for (int n = 0; n < fixedCycles; n++) begin
      driveInputs(srcNone, srcNone, 1'b0, 1'b0);
      finishCycle();
    end
    // aux beats any old-result code.
    for (int n = 0; n < fixedCycles; n++) begin
      driveInputs(srcNone, fwdSrcT'(randRange(16)), 1'b1, 1'b0);
      finishCycle();
    end
    for (int n = 0; n < randCycles; n++) begin
      mode = randRange(4);
      code = fwdSrcT'(randRange(16));
      aux  = (randRange(4) == 0);
      stl  = nextStall();
      case (mode)
        0:       driveInputs(code, srcNone, aux, stl);
        1:       driveInputs(srcNone, code, aux, stl);
        default: driveInputs(srcNone, srcNone, aux, stl);
      endcase
      finishCycle();
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- forwardTop.f
verilog/fwdPkg.sv
verilog/forwardCtrl.sv
verilog/resultDelay.sv
verilog/operandBypass.sv
verilog/forwardTop.sv
dv/forwardTb.sv

//--- verilog/forwardCtrl.sv
`timescale 1ns/1ns

module forwardCtrl import fwdPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  fwdSrcT fuFwd,
  input  fwdSrcT fuuFwd,
  input  logic   auxEn,
  input  logic   stall,
  output fwdSelT srcSel,
  output logic   captureEn
);

  logic               fuActive;
  logic               fuuActive;
  logic               auxPick;
  logic               oldPick;
  logic [fuCount-1:0] curHit;
  logic [fuCount-1:0] oldHit;

  assign fuActive  = (fuFwd != srcNone);
  assign fuuActive = (fuuFwd != srcNone);

  // current result wins, then aux, then the old result.
  assign auxPick = !fuActive && auxEn;
  assign oldPick = !fuActive && !auxEn && fuuActive;

  always_comb begin
    curHit = '0;
    oldHit = '0;
    for (int i = 0; i < fuCount; i++) begin
      curHit[i] = fuActive && (srcUnit(fuFwd) == fuIdxT'(i));
      oldHit[i] = oldPick && (srcUnit(fuuFwd) == fuIdxT'(i));
    end
  end

  always_comb begin
    srcSel = '0;
    srcSel[selCurBase +: fuCount] = curHit;
    srcSel[selOldBase +: fuCount] = oldHit;
    srcSel[selAux] = auxPick;
    srcSel[selReg] = !fuActive && !auxEn && !fuuActive; // register file fallback.
  end

  assign captureEn = !stall;

  // both bypass slices rely on exactly one candidate being picked.
  selOneHot: assert property (
    @(posedge clk) disable iff (rst) $onehot(srcSel)
  ) else $error("srcSel not one-hot: %b", srcSel);

  // scheduler never forwards current and old result to one slot.
  srcExclusive: assert property (
    @(posedge clk) disable iff (rst) !(fuActive && fuuActive)
  ) else $error("fuFwd %h and fuuFwd %h both active", fuFwd, fuuFwd);

endmodule

//--- verilog/forwardTop.sv
`timescale 1ns/1ns

module forwardTop import fwdPkg::*; #(
  parameter int dataWidth = 65,
  parameter int flagWidth = 6
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,
  input  fwdSrcT               fuFwd,
  input  fwdSrcT               fuuFwd,
  input  logic                 auxEn,
  input  logic [dataWidth-1:0] regData,
  input  logic [flagWidth-1:0] regFlags,
  input  logic [dataWidth-1:0] auxData,
  input  logic [flagWidth-1:0] auxFlags,
  input  logic [dataWidth-1:0] fuData  [fuCount],
  input  logic [flagWidth-1:0] fuFlags [fuCount],
  output logic [dataWidth-1:0] opData,
  output logic [flagWidth-1:0] opFlags
);

  typedef logic [dataWidth-1:0] dataT;
  typedef logic [flagWidth-1:0] flagT;

  fwdSelT srcSel;
  logic   captureEn;
  dataT   oldData  [fuCount];
  flagT   oldFlags [fuCount];

  // one decode shared by both payload slices.
  forwardCtrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .fuFwd     (fuFwd),
    .fuuFwd    (fuuFwd),
    .auxEn     (auxEn),
    .stall     (stall),
    .srcSel    (srcSel),
    .captureEn (captureEn)
  );

  resultDelay #(
    .payloadT (dataT)
  ) u_dataDelay (
    .clk        (clk),
    .rst        (rst),
    .results    (fuData),
    .oldResults (oldData)
  );

  resultDelay #(
    .payloadT (flagT)
  ) u_flagDelay (
    .clk        (clk),
    .rst        (rst),
    .results    (fuFlags),
    .oldResults (oldFlags)
  );

  operandBypass #(
    .payloadT (dataT)
  ) u_dataBypass (
    .clk        (clk),
    .rst        (rst),
    .srcSel     (srcSel),
    .captureEn  (captureEn),
    .curResults (fuData),
    .oldResults (oldData),
    .auxValue   (auxData),
    .regValue   (regData),
    .operand    (opData)
  );

  // attribute field, same select as the data.
  operandBypass #(
    .payloadT (flagT)
  ) u_flagBypass (
    .clk        (clk),
    .rst        (rst),
    .srcSel     (srcSel),
    .captureEn  (captureEn),
    .curResults (fuFlags),
    .oldResults (oldFlags),
    .auxValue   (auxFlags),
    .regValue   (regFlags),
    .operand    (opFlags)
  );

endmodule

//--- verilog/fwdPkg.sv
package fwdPkg;

  // functional units on the forwarding network.
  localparam int fuCount = 10;

  // unit index, wide enough for every unit.
  typedef logic [$clog2(fuCount)-1:0] fuIdxT;

  // codes 0..8 pick that unit, 9..14 all pick unit 9 and 15 is none.
  typedef logic [3:0] fwdSrcT;

  localparam fwdSrcT srcNone = 4'd15;

  // one-hot select layout.
  localparam int selWidth   = 2 * fuCount + 2;
  localparam int selCurBase = 0;         // current results.
  localparam int selOldBase = fuCount;   // one-cycle-old results.
  localparam int selAux     = 2 * fuCount;
  localparam int selReg     = 2 * fuCount + 1;

  typedef logic [selWidth-1:0] fwdSelT;

  // upper codes fold onto the last unit.
  // srcNone also folds here, so callers qualify it themselves.
  function automatic fuIdxT srcUnit(input fwdSrcT code);
    if (code > fwdSrcT'(fuCount - 1)) begin
      return fuIdxT'(fuCount - 1);
    end
    return fuIdxT'(code);
  endfunction

endpackage

//--- verilog/operandBypass.sv
`timescale 1ns/1ns

module operandBypass import fwdPkg::*; #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rst,
  input  fwdSelT  srcSel,
  input  logic    captureEn,
  input  payloadT curResults [fuCount],
  input  payloadT oldResults [fuCount],
  input  payloadT auxValue,
  input  payloadT regValue,
  output payloadT operand
);

  localparam int payloadBits = $bits(payloadT);

  logic [payloadBits-1:0] candidates [selWidth];
  logic [payloadBits-1:0] selValue;

  // candidate order follows the select layout.
  always_comb begin
    for (int i = 0; i < fuCount; i++) begin
      candidates[selCurBase + i] = curResults[i];
      candidates[selOldBase + i] = oldResults[i];
    end
    candidates[selAux] = auxValue;
    candidates[selReg] = regValue;
  end

  // and-or mux over the one-hot srcSel.
  always_comb begin
    selValue = '0;
    for (int i = 0; i < selWidth; i++) begin
      selValue = selValue | (candidates[i] & {payloadBits{srcSel[i]}});
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      operand <= '0;
    end else if (captureEn) begin
      operand <= payloadT'(selValue);
    end
  end

  // a stalled slot must not pick up any forwarded value.
  holdOnStall: assert property (
    @(posedge clk) disable iff (rst) !captureEn |=> $stable(operand)
  ) else $error("operand changed while capture was disabled");

endmodule

//--- verilog/resultDelay.sv
`timescale 1ns/1ns

module resultDelay import fwdPkg::*; #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rst,
  input  payloadT results    [fuCount],
  output payloadT oldResults [fuCount]
);

  // history runs every cycle and ignores stall.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < fuCount; i++) begin
        oldResults[i] <= '0;
      end
    end else begin
      for (int i = 0; i < fuCount; i++) begin
        oldResults[i] <= results[i];
      end
    end
  end

endmodule
